//--- masku_macros.svh
`ifndef MASKU_MACROS_SVH
`define MASKU_MACROS_SVH

// Elements per beat, also the data word width
`define MASKU_ELEN 64
// Largest vector length in elements
`define MASKU_VLEN 512
// Data words that make up one vector register
`define MASKU_WORDS_PER_VREG 8
// Entries in the result queue toward the register file
`define MASKU_RQ_DEPTH 2

// Field widths
`define MASKU_ID_W 3
`define MASKU_VREG_W 5
`define MASKU_ADDR_W 8
// Scalar result toward the dispatcher
`define MASKU_XLEN 32

`endif

//--- masku_pkg.sv
`default_nettype none

`include "masku_macros.svh"

package masku_pkg;

  // One beat of data, one bit per element
  typedef logic [`MASKU_ELEN-1:0] elen_t;

  // Element count, wide enough for the full vector length
  typedef logic [$clog2(`MASKU_VLEN+1)-1:0] vlen_t;

  // Instruction id, register number, word address in the register file
  typedef logic [`MASKU_ID_W-1:0]   vid_t;
  typedef logic [`MASKU_VREG_W-1:0] vreg_t;
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // Scalar result of a population count
  typedef logic [`MASKU_XLEN-1:0] xlen_t;

  // Mask opcodes
  // Everything but VCPOP goes down the merge path
  typedef enum logic [3:0] {
    VMAND,
    VMNAND,
    VMANDN,
    VMXOR,
    VMOR,
    VMNOR,
    VMORN,
    VMXNOR,
    VCPOP
  } masku_op_e;

endpackage

`default_nettype wire

//--- masku_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "masku_macros.svh"

// Sequencer to ALU, the instruction being issued
interface masku_issue_if;
  import masku_pkg::*;

  logic                                         issue_valid;
  masku_op_e                                    op;
  logic                                         vm;
  vreg_t                                        vd;
  vid_t                                         id;
  // Elements still to issue
  vlen_t                                        remaining;
  // Word index inside the destination register
  logic [$clog2(`MASKU_WORDS_PER_VREG)-1:0]     beat_idx;
  // One pulse per consumed beat
  logic                                         fire;

  modport seq (output issue_valid, op, vm, vd, id, remaining, beat_idx, input fire);
  modport alu (input issue_valid, op, vm, vd, id, remaining, beat_idx, output fire);
endinterface

// ALU to result queue, one merged word per push
interface masku_push_if;
  import masku_pkg::*;

  logic   push;
  elen_t  wdata;
  vaddr_t addr;
  vid_t   id;
  logic   full;

  modport alu   (output push, wdata, addr, id, input full);
  modport queue (input push, wdata, addr, id, output full);
endinterface

`default_nettype wire

//--- masku_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "masku_macros.svh"

module masku_sequencer (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Instruction request
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  input  masku_pkg::masku_op_e     op_i,
  input  masku_pkg::vlen_t         vl_i,
  input  wire logic                vm_i,
  input  masku_pkg::vreg_t         vd_i,
  input  masku_pkg::vid_t          id_i,
  // Toward the ALU
  masku_issue_if.seq               issue,
  // Result queue drained
  input  wire logic                queue_empty_i,
  // Completion
  output logic                     done_o,
  output masku_pkg::vid_t          done_id_o
);
  import masku_pkg::*;

  localparam vlen_t beat_elems = vlen_t'(`MASKU_ELEN);

  //////////////////////////////
  // Held instruction

  // Single-entry instruction queue
  logic      valid_q;
  masku_op_e op_q;
  logic      vm_q;
  vreg_t     vd_q;
  vid_t      id_q;

  // Progress of the held instruction
  vlen_t                                    remaining_q;
  logic [$clog2(`MASKU_WORDS_PER_VREG)-1:0] beat_idx_q;

  logic done_q;
  vid_t done_id_q;

  logic accept;
  logic last_beat;
  logic complete;

  // Stay closed through the done cycle
  assign req_ready_o = !valid_q && !done_q;
  assign accept      = req_valid_i && req_ready_o;

  // Beats stop once all elements are out
  assign issue.issue_valid = valid_q && (remaining_q != '0);
  assign issue.op          = op_q;
  assign issue.vm          = vm_q;
  assign issue.vd          = vd_q;
  assign issue.id          = id_q;
  assign issue.remaining   = remaining_q;
  assign issue.beat_idx    = beat_idx_q;

  //////////////////////////////
  // Completion

  assign last_beat = (remaining_q <= beat_elems);

  // VCPOP ends on its last fire
  // A merge ends once every word left the queue
  // vl of zero falls through both with no beat
  always_comb begin
    if (op_q == VCPOP) begin
      complete = valid_q && ((remaining_q == '0) || (issue.fire && last_beat));
    end else begin
      complete = valid_q && (remaining_q == '0) && queue_empty_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      remaining_q <= '0;
      beat_idx_q  <= '0;
      done_q      <= 1'b0;
      done_id_q   <= '0;
    end else begin
      done_q <= complete;
      if (complete) begin
        valid_q   <= 1'b0;
        done_id_q <= id_q;
      end
      if (accept) begin
        valid_q     <= 1'b1;
        remaining_q <= vl_i;
        beat_idx_q  <= '0;
      end else if (issue.fire) begin
        // Saturate at zero on the tail beat
        remaining_q <= last_beat ? '0 : remaining_q - beat_elems;
        beat_idx_q  <= beat_idx_q + 1'b1;
      end
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= op_i;
      vm_q <= vm_i;
      vd_q <= vd_i;
      id_q <= id_i;
    end
  end

  assign done_o    = done_q;
  assign done_id_o = done_id_q;

  // ALU only consumes beats of an issued instruction
  a_fire_needs_issue : assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue.fire |-> issue.issue_valid
  );

endmodule

`default_nettype wire

//--- masku_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "masku_macros.svh"

module masku_alu (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  masku_issue_if.alu          issue,
  masku_push_if.alu           push,
  // ALU result
  input  masku_pkg::elen_t    a_i,
  input  wire logic           a_valid_i,
  output logic                a_ready_o,
  // Old destination value
  input  masku_pkg::elen_t    b_i,
  input  wire logic           b_valid_i,
  output logic                b_ready_o,
  // Mask
  input  masku_pkg::elen_t    m_i,
  input  wire logic           m_valid_i,
  output logic                m_ready_o,
  // Scalar result toward the dispatcher
  output masku_pkg::xlen_t    scalar_o,
  output logic                scalar_valid_o,
  input  wire logic           scalar_ready_i
);
  import masku_pkg::*;

  localparam int unsigned elen  = `MASKU_ELEN;
  localparam int unsigned cnt_w = $clog2(elen) + 1;

  elen_t            len_en;
  elen_t            bit_en;
  elen_t            merged;
  elen_t            cpop_bits;
  logic [cnt_w-1:0] beat_cnt;
  logic             is_cpop;
  logic             mask_ok;
  logic             last_beat;
  logic             fire_merge;
  logic             fire_cpop;
  xlen_t            acc_q;
  xlen_t            acc_sum;
  xlen_t            scalar_q;
  logic             scalar_valid_q;

  //////////////////////////////
  // Bit enable and merge

  // Low min(remaining, ELEN) bits, then the mask when vm is low
  always_comb begin
    for (int i = 0; i < elen; i++) begin
      len_en[i] = (issue.remaining > vlen_t'(i));
    end
  end
  assign bit_en = len_en & (issue.vm ? '1 : m_i);

  // a where enabled, b kept elsewhere
  assign merged    = (a_i & bit_en) | (b_i & ~bit_en);
  assign cpop_bits = b_i & bit_en;

  always_comb begin
    beat_cnt = '0;
    for (int i = 0; i < elen; i++) begin
      beat_cnt = beat_cnt + cnt_w'(cpop_bits[i]);
    end
  end

  //////////////////////////////
  // Beat handshake

  assign is_cpop   = (issue.op == VCPOP);
  assign mask_ok   = issue.vm || m_valid_i;
  assign last_beat = (issue.remaining <= vlen_t'(elen));

  assign fire_merge = issue.issue_valid && !is_cpop && a_valid_i && b_valid_i && mask_ok &&
                      !push.full;
  // Stall while the previous count is still unread
  assign fire_cpop  = issue.issue_valid && is_cpop && b_valid_i && mask_ok && !scalar_valid_q;

  assign issue.fire = fire_merge || fire_cpop;
  assign a_ready_o  = fire_merge;
  assign b_ready_o  = issue.fire;
  assign m_ready_o  = issue.fire && !issue.vm;

  // Word goes to vd * words per register + beat
  assign push.push  = fire_merge;
  assign push.wdata = merged;
  assign push.addr  = vaddr_t'(issue.vd * `MASKU_WORDS_PER_VREG) + vaddr_t'(issue.beat_idx);
  assign push.id    = issue.id;

  //////////////////////////////
  // Popcount and scalar

  assign acc_sum = acc_q + xlen_t'(beat_cnt);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q          <= '0;
      scalar_valid_q <= 1'b0;
    end else begin
      if (scalar_valid_q && scalar_ready_i) begin
        scalar_valid_q <= 1'b0;
      end
      if (fire_cpop) begin
        // Last beat hands the total over and restarts the count
        acc_q <= last_beat ? '0 : acc_sum;
        if (last_beat) begin
          scalar_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire_cpop && last_beat) begin
      scalar_q <= acc_sum;
    end
  end

  assign scalar_o       = scalar_q;
  assign scalar_valid_o = scalar_valid_q;

  // Dispatcher sees a steady value until it takes it
  a_scalar_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    scalar_valid_o && !scalar_ready_i |=> $stable(scalar_o)
  );

endmodule

`default_nettype wire

//--- masku_result_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "masku_macros.svh"

module masku_result_queue (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  masku_push_if.queue        push,
  output logic               queue_empty_o,
  // Register file write port
  output logic               result_req_o,
  output masku_pkg::vaddr_t  result_addr_o,
  output masku_pkg::vid_t    result_id_o,
  output masku_pkg::elen_t   result_wdata_o,
  input  wire logic          result_gnt_i
);
  import masku_pkg::*;

  localparam int unsigned depth = `MASKU_RQ_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  //////////////////////////////
  // Storage

  elen_t  wdata_q [depth];
  vaddr_t addr_q  [depth];
  vid_t   id_q    [depth];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;

  logic empty;
  logic pop;

  assign empty     = (cnt_q == '0);
  assign push.full = (cnt_q == cnt_w'(depth));
  assign pop       = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i) begin
    if (push.push) begin
      wdata_q[wr_ptr_q] <= push.wdata;
      addr_q[wr_ptr_q]  <= push.addr;
      id_q[wr_ptr_q]    <= push.id;
    end
  end

  //////////////////////////////
  // Pointers and count

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push.push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push.push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //////////////////////////////
  // Head toward the register file

  // Held until granted
  assign result_req_o   = !empty;
  assign result_addr_o  = addr_q[rd_ptr_q];
  assign result_id_o    = id_q[rd_ptr_q];
  assign result_wdata_o = wdata_q[rd_ptr_q];

  assign queue_empty_o = empty;

  // ALU holds merge beats back while the queue is full
  a_no_push_when_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push.push |-> !push.full
  );

endmodule

`default_nettype wire

//--- masku_top.sv
`timescale 1ns/1ps
`default_nettype none

module masku_top (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  // Instruction from the sequencer
  input  wire logic              req_valid_i,
  output logic                   req_ready_o,
  input  masku_pkg::masku_op_e   op_i,
  input  masku_pkg::vlen_t       vl_i,
  input  wire logic              vm_i,
  input  masku_pkg::vreg_t       vd_i,
  input  masku_pkg::vid_t        id_i,
  // Operand beats
  input  masku_pkg::elen_t       a_i,
  input  wire logic              a_valid_i,
  output logic                   a_ready_o,
  input  masku_pkg::elen_t       b_i,
  input  wire logic              b_valid_i,
  output logic                   b_ready_o,
  input  masku_pkg::elen_t       m_i,
  input  wire logic              m_valid_i,
  output logic                   m_ready_o,
  // Register file writes
  output logic                   result_req_o,
  output masku_pkg::vaddr_t      result_addr_o,
  output masku_pkg::vid_t        result_id_o,
  output masku_pkg::elen_t       result_wdata_o,
  input  wire logic              result_gnt_i,
  // Scalar result toward the dispatcher
  output masku_pkg::xlen_t       scalar_o,
  output logic                   scalar_valid_o,
  input  wire logic              scalar_ready_i,
  // Completion
  output logic                   done_o,
  output masku_pkg::vid_t        done_id_o
);

  masku_issue_if issue_if ();
  masku_push_if  push_if ();

  logic queue_empty;

  // Input side
  masku_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .op_i          (op_i),
    .vl_i          (vl_i),
    .vm_i          (vm_i),
    .vd_i          (vd_i),
    .id_i          (id_i),
    .issue         (issue_if.seq),
    .queue_empty_i (queue_empty),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  // Merge and popcount
  masku_alu u_alu (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue          (issue_if.alu),
    .push           (push_if.alu),
    .a_i            (a_i),
    .a_valid_i      (a_valid_i),
    .a_ready_o      (a_ready_o),
    .b_i            (b_i),
    .b_valid_i      (b_valid_i),
    .b_ready_o      (b_ready_o),
    .m_i            (m_i),
    .m_valid_i      (m_valid_i),
    .m_ready_o      (m_ready_o),
    .scalar_o       (scalar_o),
    .scalar_valid_o (scalar_valid_o),
    .scalar_ready_i (scalar_ready_i)
  );

  // Output side toward the register file
  masku_result_queue u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push           (push_if.queue),
    .queue_empty_o  (queue_empty),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

`default_nettype wire

//--- tb_masku.sv
`timescale 1ns/1ps
`default_nettype none

`include "masku_macros.svh"

module tb_masku;
  import masku_pkg::*;

  localparam int num_tests   = 8;
  localparam int half_period = 20;
  localparam int elen        = `MASKU_ELEN;
  localparam int max_beats   = `MASKU_WORDS_PER_VREG;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      req_valid_i;
  logic      req_ready_o;
  masku_op_e op_i;
  vlen_t     vl_i;
  logic      vm_i;
  vreg_t     vd_i;
  vid_t      id_i;
  elen_t     a_i;
  logic      a_valid_i;
  logic      a_ready_o;
  elen_t     b_i;
  logic      b_valid_i;
  logic      b_ready_o;
  elen_t     m_i;
  logic      m_valid_i;
  logic      m_ready_o;
  logic      result_req_o;
  vaddr_t    result_addr_o;
  vid_t      result_id_o;
  elen_t     result_wdata_o;
  logic      result_gnt_i;
  xlen_t     scalar_o;
  logic      scalar_valid_o;
  logic      scalar_ready_i;
  logic      done_o;
  vid_t      done_id_o;

  // Instruction under test
  masku_op_e cur_op = VMAND;
  int        cur_vl = 0;
  logic      cur_vm = 1'b1;
  int        cur_id = 0;
  int        n_beats = 0;
  logic      throttle = 1'b0;
  logic      ops_active = 1'b0;

  // Operand beats with one per word of the register
  elen_t a_mem [max_beats];
  elen_t b_mem [max_beats];
  elen_t m_mem [max_beats];
  int    a_idx = 0;
  int    b_idx = 0;
  int    m_idx = 0;
  int    hold_cnt = 0;

  // Expected register file writes with the oldest first
  elen_t  exp_data [$];
  vaddr_t exp_addr [$];
  xlen_t  exp_scalar;
  logic   done_seen = 1'b0;
  logic   scalar_taken = 1'b0;

  int err_cnt = 0;
  int test_cnt = 0;
  int fail_cnt = 0;

  logic [15:0] lfsr_q = 16'd53940;

  masku_top dut (.*);

  always #(half_period) clk_i = ~clk_i;

  //////////////////////////////
  // Random source

  // Taps of x^16 + x^14 + x^13 + x^11 + 1
  // One step per bit
  function automatic logic coin();
    lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
    return lfsr_q[0];
  endfunction

  function automatic elen_t take_word();
    elen_t w;
    w = '0;
    for (int i = 0; i < elen; i++) begin
      w = {w[elen-2:0], coin()};
    end
    return w;
  endfunction

  //////////////////////////////
  // Reference model

  // Element inside vl, and its mask bit set unless vm
  function automatic elen_t bit_enable(input int beat);
    elen_t en;
    for (int i = 0; i < elen; i++) begin
      en[i] = ((beat * elen + i) < cur_vl) && (cur_vm || m_mem[beat][i]);
    end
    return en;
  endfunction

  function automatic elen_t ref_word(input int beat);
    elen_t en;
    en = bit_enable(beat);
    return (a_mem[beat] & en) | (b_mem[beat] & ~en);
  endfunction

  function automatic xlen_t ref_count();
    xlen_t cnt;
    elen_t en;
    cnt = '0;
    for (int k = 0; k < n_beats; k++) begin
      en = bit_enable(k);
      for (int i = 0; i < elen; i++) begin
        cnt = cnt + xlen_t'(b_mem[k][i] & en[i]);
      end
    end
    return cnt;
  endfunction

  //////////////////////////////
  // Error helpers

  task automatic note_mismatch(input string sig, input logic [63:0] exp_v,
                               input logic [63:0] got_v);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, sig, exp_v, got_v);
    err_cnt++;
  endtask

  task automatic note_error(input string what);
    $display("error at %0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic check_idle();
    if (req_ready_o !== 1'b1) note_mismatch("req_ready_o", 1, req_ready_o);
    if (result_req_o !== 1'b0) note_mismatch("result_req_o", 0, result_req_o);
    if (scalar_valid_o !== 1'b0) note_mismatch("scalar_valid_o", 0, scalar_valid_o);
    if (done_o !== 1'b0) note_mismatch("done_o", 0, done_o);
    if (a_ready_o !== 1'b0) note_mismatch("a_ready_o", 0, a_ready_o);
    if (b_ready_o !== 1'b0) note_mismatch("b_ready_o", 0, b_ready_o);
    if (m_ready_o !== 1'b0) note_mismatch("m_ready_o", 0, m_ready_o);
  endtask

  task automatic report(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s finished, ok", name);
    end else begin
      fail_cnt++;
      $display("test %s finished, %0d errors", name, err_cnt - errs_before);
    end
  endtask

  //////////////////////////////
  // Operand, grant and scalar drivers

  // Operands the instruction does not use are offered too and must not be taken
  always @(posedge clk_i) begin
    if (ops_active) begin
      // Count the beats taken at this edge
      if (a_valid_i && a_ready_o) a_idx = a_idx + 1;
      if (b_valid_i && b_ready_o) b_idx = b_idx + 1;
      if (m_valid_i && m_ready_o) m_idx = m_idx + 1;
      a_valid_i    <= (a_idx < n_beats) && (!throttle || coin());
      b_valid_i    <= (b_idx < n_beats) && (!throttle || coin());
      m_valid_i    <= (m_idx < n_beats) && (!throttle || coin());
      a_i          <= (a_idx < max_beats) ? a_mem[a_idx] : '0;
      b_i          <= (b_idx < max_beats) ? b_mem[b_idx] : '0;
      m_i          <= (m_idx < max_beats) ? m_mem[m_idx] : '0;
      result_gnt_i <= !throttle || coin();
    end else begin
      a_valid_i    <= 1'b0;
      b_valid_i    <= 1'b0;
      m_valid_i    <= 1'b0;
      result_gnt_i <= 1'b0;
    end
  end

  // Dispatcher leaves the count waiting a few cycles
  always @(posedge clk_i) begin
    if (scalar_valid_o && scalar_ready_i) begin
      scalar_ready_i <= 1'b0;
      hold_cnt = 0;
    end else if (scalar_valid_o) begin
      hold_cnt = hold_cnt + 1;
      scalar_ready_i <= (hold_cnt >= 4);
    end
  end

  //////////////////////////////
  // Checker

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (result_req_o && cur_op == VCPOP) note_error("register file write during VCPOP");
      if (result_req_o && result_gnt_i) begin
        if (exp_data.size() == 0) begin
          note_error("register file write that was not expected");
        end else begin
          if (result_wdata_o !== exp_data[0]) begin
            note_mismatch("result_wdata_o", exp_data[0], result_wdata_o);
          end
          if (result_addr_o !== exp_addr[0]) begin
            note_mismatch("result_addr_o", exp_addr[0], result_addr_o);
          end
          if (result_id_o !== vid_t'(cur_id)) note_mismatch("result_id_o", cur_id, result_id_o);
          void'(exp_data.pop_front());
          void'(exp_addr.pop_front());
        end
      end
      // Compared every cycle it is held, so a changing value shows up
      if (scalar_valid_o) begin
        if (cur_op != VCPOP) begin
          note_error("scalar_valid_o high outside VCPOP");
        end else if (scalar_o !== exp_scalar) begin
          note_mismatch("scalar_o", exp_scalar, scalar_o);
        end
        if (scalar_ready_i) scalar_taken = 1'b1;
      end
      if (done_o) begin
        if (done_seen) note_error("second done_o pulse for one instruction");
        if (done_id_o !== vid_t'(cur_id)) note_mismatch("done_id_o", cur_id, done_id_o);
        if (exp_data.size() != 0) note_error("done_o before the last register file write");
        done_seen = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Tests

  task automatic run_test(input string name, input masku_op_e op, input int vl,
                          input logic vm, input int vd, input int id, input logic thr);
    int errs_before;
    errs_before = err_cnt;
    cur_op   = op;
    cur_vl   = vl;
    cur_vm   = vm;
    cur_id   = id;
    throttle = thr;
    n_beats  = (vl + elen - 1) / elen;
    for (int k = 0; k < max_beats; k++) begin
      a_mem[k] = take_word();
      b_mem[k] = take_word();
      m_mem[k] = take_word();
    end
    exp_data.delete();
    exp_addr.delete();
    if (op != VCPOP) begin
      for (int k = 0; k < n_beats; k++) begin
        exp_data.push_back(ref_word(k));
        exp_addr.push_back(vaddr_t'(vd * max_beats + k));
      end
    end
    exp_scalar   = ref_count();
    a_idx        = 0;
    b_idx        = 0;
    m_idx        = 0;
    done_seen    = 1'b0;
    scalar_taken = 1'b0;
    @(negedge clk_i);
    ops_active = 1'b1;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    op_i        <= op;
    vl_i        <= vlen_t'(vl);
    vm_i        <= vm;
    vd_i        <= vreg_t'(vd);
    id_i        <= vid_t'(id);
    do @(posedge clk_i); while (!req_ready_o);
    req_valid_i <= 1'b0;
    // A zero-length VCPOP has no count to hand over
    wait (done_seen && (op != VCPOP || vl == 0 || scalar_taken));
    @(negedge clk_i);
    ops_active = 1'b0;
    if (exp_data.size() != 0) note_error("register file writes missing at done_o");
    if (b_idx != n_beats) note_error($sformatf("b took %0d beats, not %0d", b_idx, n_beats));
    if (a_idx != ((op == VCPOP) ? 0 : n_beats)) note_error("a took a wrong number of beats");
    if (m_idx != (vm ? 0 : n_beats)) note_error("m took a wrong number of beats");
    report(name, errs_before);
  endtask

  initial begin
    rst_ni         <= 1'b0;
    req_valid_i    <= 1'b0;
    op_i           <= VMAND;
    vl_i           <= '0;
    vm_i           <= 1'b1;
    vd_i           <= '0;
    id_i           <= '0;
    a_i            <= '0;
    a_valid_i      <= 1'b0;
    b_i            <= '0;
    b_valid_i      <= 1'b0;
    m_i            <= '0;
    m_valid_i      <= 1'b0;
    result_gnt_i   <= 1'b0;
    scalar_ready_i <= 1'b0;
    // Idle outputs in the middle of reset and just after it
    repeat (8) @(posedge clk_i);
    check_idle();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_idle();
    report("reset", 0);
    @(negedge clk_i);
    run_test("merge_full", VMAND, 512, 1'b1, 3, 1, 1'b0);
    run_test("tail", VMXOR, 100, 1'b1, 5, 2, 1'b0);
    run_test("masked", VMOR, 300, 1'b0, 7, 3, 1'b0);
    run_test("vcpop", VCPOP, 450, 1'b0, 0, 4, 1'b0);
    run_test("vcpop_unmasked", VCPOP, 200, 1'b1, 0, 5, 1'b0);
    run_test("backpressure", VMNAND, 512, 1'b0, 31, 6, 1'b1);
    run_test("vl_zero", VMAND, 0, 1'b1, 2, 7, 1'b0);
    $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Budget of 400 cycles per test
  initial begin
    #(num_tests * 400 * 2 * half_period);
    $display("timeout: tests did not finish within %0d cycles", num_tests * 400);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
masku_pkg.sv
masku_if.sv
masku_sequencer.sv
masku_alu.sv
masku_result_queue.sv
masku_top.sv
tb_masku.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_masku -f sources.f \
  -o sim_masku || exit 1
./obj_dir/sim_masku > sim.log 2>&1
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0
